//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_rip_front \
		-f rip_front.f -o sim_rip_front

run: compile
	@out="$$(./obj_dir/sim_rip_front)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

//--- dv/tb_rip_front.sv
`timescale 1ns/1ps

module tb_rip_front;
    import rip_pkg::*;

    typedef enum {issue, stall, bubble} mode_e;

    typedef struct {
        string       name;
        logic [31:0] word;
        logic [31:0] pc;
        mode_e       mode;
        logic        wb_en;
        logic [4:0]  wb_rd;
        logic [31:0] wb_data;
        inst_t       flags;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        de_ready;
    logic        ex_stall;
    logic [31:0] inst_code;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    rip_ex_req_t ex_req;

    logic [31:0] shadow [0:31];
    row_t        tbl [0:31];
    int          row_cnt;
    int          errors;
    int          passed;
    rip_ex_req_t exp_req;
    rip_ex_req_t prev_req;

    rip_front rip_front_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .de_ready  (de_ready),
        .ex_stall  (ex_stall),
        .inst_code (inst_code),
        .pc        (pc),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .ex_req    (ex_req)
    );

    always #2 clk = ~clk;

    task automatic add_row(input string name, input logic [31:0] word, input mode_e mode);
        tbl[row_cnt].name    = name;
        tbl[row_cnt].word    = word;
        tbl[row_cnt].pc      = 32'h0000_1000 + 32'(row_cnt * 4);
        tbl[row_cnt].mode    = mode;
        tbl[row_cnt].wb_en   = 1'b0;
        tbl[row_cnt].wb_rd   = 5'd0;
        tbl[row_cnt].wb_data = 32'd0;
        tbl[row_cnt].flags   = '0;
        row_cnt++;
    endtask

    // expected request from the RV32 encoding rules and the shadow registers
    function automatic rip_ex_req_t expect_req(input logic [31:0] w, input logic [31:0] pc_v,
                                               input inst_t flags);
        rip_ex_req_t r;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        csr_op;
        logic        i_type;
        logic        rs1_used;
        logic        rs2_used;
        logic        rd_used;
        logic [31:0] imm_v;
        logic [31:0] a_v;
        logic [31:0] b_v;
        opc      = w[6:0];
        f3       = w[14:12];
        csr_op   = opc == op_system && f3 != 3'b000;
        i_type   = opc == op_imm || opc == op_load || opc == op_jalr;
        rs1_used = opc == op_reg || i_type || opc == op_store || opc == op_branch ||
            (csr_op && !f3[2]);
        rs2_used = opc == op_reg || opc == op_store || opc == op_branch;
        rd_used  = opc == op_reg || i_type || opc == op_lui || opc == op_auipc ||
            opc == op_jal || csr_op;
        imm_v = '0;
        if (opc == op_imm && f3[1:0] == 2'b01) begin
            imm_v = {27'b0, w[24:20]};
        end else if (i_type) begin
            imm_v = {{20{w[31]}}, w[31:20]};
        end else if (opc == op_store) begin
            imm_v = {{20{w[31]}}, w[31:25], w[11:7]};
        end else if (opc == op_lui || opc == op_auipc) begin
            imm_v = {w[31:12], 12'b0};
        end
        a_v = rs1_used ? shadow[w[19:15]] : 32'd0;
        b_v = rs2_used ? shadow[w[24:20]] : 32'd0;

        r                 = '0;
        r.valid           = 1'b1;
        r.inst            = flags;
        r.rd              = rd_used ? w[11:7] : 5'd0;
        r.inst.access_mem = opc == op_load || opc == op_store;
        r.inst.update_reg = r.rd != 5'd0;
        r.inst.update_csr = csr_op;
        r.inst.update_pc  = opc == op_jal || opc == op_jalr || opc == op_branch ||
            (opc == op_system && f3 == 3'b000);
        r.csr_num         = csr_op ? w[31:20] : 12'd0;
        r.csr_zimm        = (csr_op && f3[2]) ? w[19:15] : 5'd0;
        r.pc              = pc_v;
        r.store_data      = b_v;
        if (opc == op_auipc || opc == op_jal) begin
            r.op_a = pc_v;
        end else if (opc == op_lui) begin
            r.op_a = 32'd0;
        end else if (csr_op && f3[2]) begin
            r.op_a = {27'b0, w[19:15]};
        end else begin
            r.op_a = a_v;
        end
        if (opc == op_reg || opc == op_branch) begin
            r.op_b = b_v;
        end else if (opc == op_jal || opc == op_jalr) begin
            r.op_b = 32'd4;
        end else begin
            r.op_b = imm_v;
        end
        return r;
    endfunction

    task automatic wait_reset_clear();
        int cycles;
        cycles = 0;
        while (ex_req !== '0 && cycles < 10) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (ex_req !== '0) begin
            $display("timeout: ex_req did not clear to zero after reset");
            errors++;
        end else begin
            $display("ok       reset");
            passed++;
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        de_ready  = 1'b0;
        // stage holds through reset, so only the reset itself can zero it
        ex_stall  = 1'b1;
        inst_code = '0;
        pc        = '0;
        wb_en     = 1'b0;
        wb_rd     = '0;
        wb_data   = '0;
        row_cnt   = 0;
        errors    = 0;
        passed    = 0;
        prev_req  = '0;
        void'($urandom(32'hd53f));

        add_row("addi_neg", {12'hff6, 5'd5, 3'b000, 5'd7, op_imm}, issue);
        tbl[row_cnt-1].flags.addi = 1'b1;
        add_row("srai_shamt", {7'b0100000, 5'd31, 5'd4, 3'b101, 5'd8, op_imm}, issue);
        tbl[row_cnt-1].flags.srai = 1'b1;
        add_row("lw", {12'h7fc, 5'd2, 3'b010, 5'd10, op_load}, issue);
        tbl[row_cnt-1].flags.lw = 1'b1;
        add_row("sw", {7'h7f, 5'd6, 5'd2, 3'b010, 5'h18, op_store}, issue);
        tbl[row_cnt-1].flags.sw = 1'b1;
        add_row("bne", {7'b1000000, 5'd4, 5'd3, 3'b001, 5'b01011, op_branch}, issue);
        tbl[row_cnt-1].flags.bne = 1'b1;
        add_row("lui", {20'hdeadb, 5'd9, op_lui}, issue);
        tbl[row_cnt-1].flags.lui = 1'b1;
        add_row("auipc", {20'h00012, 5'd11, op_auipc}, issue);
        tbl[row_cnt-1].flags.auipc = 1'b1;
        add_row("jal", {1'b1, 10'h155, 1'b1, 8'h3c, 5'd1, op_jal}, issue);
        tbl[row_cnt-1].flags.jal = 1'b1;
        add_row("add", {7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, op_reg}, issue);
        tbl[row_cnt-1].flags.add = 1'b1;
        // a write to x0 must not show up on the read
        add_row("add_x0_src", {7'b0000000, 5'd7, 5'd0, 3'b000, 5'd5, op_reg}, issue);
        tbl[row_cnt-1].flags.add = 1'b1;
        tbl[row_cnt-1].wb_en     = 1'b1;
        tbl[row_cnt-1].wb_data   = 32'hffff_ffff;
        add_row("addi_x0_dst", {12'h005, 5'd1, 3'b000, 5'd0, op_imm}, issue);
        tbl[row_cnt-1].flags.addi = 1'b1;
        add_row("sub_bypass", {7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3, op_reg}, issue);
        tbl[row_cnt-1].flags.sub = 1'b1;
        tbl[row_cnt-1].wb_en     = 1'b1;
        tbl[row_cnt-1].wb_rd     = 5'd1;
        tbl[row_cnt-1].wb_data   = 32'h1234_5678;
        add_row("stall_hold", 32'd0, stall);
        tbl[row_cnt-1].wb_en   = 1'b1;
        tbl[row_cnt-1].wb_rd   = 5'd2;
        tbl[row_cnt-1].wb_data = 32'h0bad_cafe;
        add_row("stall_again", 32'd0, stall);
        add_row("bubble", 32'd0, bubble);
        add_row("csrrw", {12'h305, 5'd6, 3'b001, 5'd12, op_system}, issue);
        tbl[row_cnt-1].flags.csrrw = 1'b1;
        add_row("csrrsi", {12'h300, 5'd21, 3'b110, 5'd13, op_system}, issue);
        tbl[row_cnt-1].flags.csrrsi = 1'b1;
        add_row("ecall", {12'h000, 5'd0, 3'b000, 5'd0, op_system}, issue);
        tbl[row_cnt-1].flags.ecall = 1'b1;
        add_row("ebreak", {12'h001, 5'd0, 3'b000, 5'd0, op_system}, issue);
        tbl[row_cnt-1].flags.ebreak = 1'b1;
        add_row("mret", {12'h302, 5'd0, 3'b000, 5'd0, op_system}, issue);
        tbl[row_cnt-1].flags.mret = 1'b1;
        add_row("mul", {7'b0000001, 5'd2, 5'd1, 3'b000, 5'd14, op_reg}, issue);
        tbl[row_cnt-1].flags.mul = 1'b1;
        add_row("divu", {7'b0000001, 5'd4, 5'd3, 3'b101, 5'd15, op_reg}, issue);
        tbl[row_cnt-1].flags.divu = 1'b1;
        add_row("remu", {7'b0000001, 5'd6, 5'd5, 3'b111, 5'd16, op_reg}, issue);
        tbl[row_cnt-1].flags.remu = 1'b1;
        add_row("bubble_end", 32'd0, bubble);

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_reset_clear();
        ex_stall = 1'b0;

        // random register contents through the writeback port
        shadow[0] = 32'd0;
        for (int r = 1; r < 32; r++) begin
            wb_en     = 1'b1;
            wb_rd     = 5'(r);
            wb_data   = $urandom;
            shadow[r] = wb_data;
            @(posedge clk);
            #1;
        end
        wb_en = 1'b0;

        for (int i = 0; i < row_cnt; i++) begin
            de_ready  = tbl[i].mode == issue;
            ex_stall  = tbl[i].mode == stall;
            inst_code = tbl[i].word;
            pc        = tbl[i].pc;
            wb_en     = tbl[i].wb_en;
            wb_rd     = tbl[i].wb_rd;
            wb_data   = tbl[i].wb_data;
            // same-edge write is visible to the read
            if (tbl[i].wb_en && tbl[i].wb_rd != 5'd0) begin
                shadow[tbl[i].wb_rd] = tbl[i].wb_data;
            end
            case (tbl[i].mode)
                issue:   exp_req = expect_req(tbl[i].word, tbl[i].pc, tbl[i].flags);
                stall:   exp_req = prev_req;
                default: exp_req = '0;
            endcase
            @(posedge clk);
            #1;
            if (ex_req !== exp_req) begin
                $display("MISMATCH %s expected %h actual %h", tbl[i].name, exp_req, ex_req);
                errors++;
            end else begin
                $display("ok       %s", tbl[i].name);
                passed++;
            end
            prev_req = exp_req;
        end

        $display("tests %0d, passed %0d, failed %0d", row_cnt + 1, passed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- rip_front.f
verilog/rip_pkg.sv
verilog/rip_decode.sv
verilog/rip_regfile.sv
verilog/rip_operand_sel.sv
verilog/rip_front.sv
dv/tb_rip_front.sv

//--- verilog/rip_decode.sv
`timescale 1ns/1ps

module rip_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               de_ready,
    input  logic               ex_stall,
    input  rip_pkg::rip_inst_u inst_code,
    output logic [4:0]         if_rs1_num,
    output logic [4:0]         if_rs2_num,
    output logic [4:0]         de_rd_num,
    output logic [4:0]         de_rs1_num,
    output logic [4:0]         de_rs2_num,
    output logic [11:0]        de_csr_num,
    output logic [4:0]         csr_zimm,
    output logic [31:0]        imm,
    output rip_pkg::inst_t     inst,
    output logic               de_valid
);
    import rip_pkg::*;

    logic [31:0] word;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] imm12;

    logic is_branch, is_load, is_store, is_imm, is_reg, is_fence, is_system;
    logic f7_base, f7_alt, f7_md;
    logic r_form, i_form, s_form, b_form, u_form, j_form, csr_form, csr_i_form;

    logic [4:0]  rd_num_gated;
    logic [11:0] csr_num_gated;
    logic [31:0] imm_next;
    inst_t       inst_next;

    assign word   = inst_code;
    assign opcode = inst_code.r_view.opcode;
    assign funct3 = inst_code.r_view.funct3;
    assign funct7 = inst_code.r_view.funct7;
    assign imm12  = inst_code.i_view.imm12;

    assign is_branch = opcode == op_branch;
    assign is_load   = opcode == op_load;
    assign is_store  = opcode == op_store;
    assign is_imm    = opcode == op_imm;
    assign is_reg    = opcode == op_reg;
    assign is_fence  = opcode == op_fence;
    assign is_system = opcode == op_system;

    assign f7_base = funct7 == funct7_base;
    assign f7_alt  = funct7 == funct7_alt;
    assign f7_md   = funct7 == funct7_muldiv;

    // instruction form
    assign r_form     = is_reg;
    assign i_form     = is_imm || is_load || opcode == op_jalr;
    assign s_form     = is_store;
    assign b_form     = is_branch;
    assign u_form     = opcode == op_lui || opcode == op_auipc;
    assign j_form     = opcode == op_jal;
    assign csr_form   = is_system && funct3 != 3'b000 && !funct3[2];
    assign csr_i_form = is_system && funct3[2];

    // register numbers only where the form reads or writes them
    assign if_rs1_num = (de_ready && (r_form || i_form || s_form || b_form || csr_form)) ?
        inst_code.r_view.rs1 : 5'd0;
    assign if_rs2_num = (de_ready && (r_form || s_form || b_form)) ?
        inst_code.r_view.rs2 : 5'd0;
    assign rd_num_gated = (de_ready && (r_form || i_form || u_form || j_form ||
        csr_form || csr_i_form)) ? inst_code.r_view.rd : 5'd0;
    assign csr_num_gated = (de_ready && (csr_form || csr_i_form)) ? imm12 : 12'd0;

    always_comb begin
        imm_next = '0;
        if (i_form) begin
            // shift amount is unsigned
            if (is_imm && funct3[1:0] == 2'b01) begin
                imm_next = {27'b0, inst_code.r_view.rs2};
            end else begin
                imm_next = {{20{imm12[11]}}, imm12};
            end
        end else if (s_form) begin
            imm_next = {{20{word[31]}}, word[31:25], word[11:7]};
        end else if (b_form) begin
            imm_next = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
        end else if (u_form) begin
            imm_next = {word[31:12], 12'b0};
        end else if (j_form) begin
            imm_next = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
        end
    end

    always_comb begin
        inst_next = '0;
        inst_next.lui     = opcode == op_lui;
        inst_next.auipc   = opcode == op_auipc;
        inst_next.jal     = opcode == op_jal;
        inst_next.jalr    = opcode == op_jalr;
        inst_next.beq     = is_branch && funct3 == 3'b000;
        inst_next.bne     = is_branch && funct3 == 3'b001;
        inst_next.blt     = is_branch && funct3 == 3'b100;
        inst_next.bge     = is_branch && funct3 == 3'b101;
        inst_next.bltu    = is_branch && funct3 == 3'b110;
        inst_next.bgeu    = is_branch && funct3 == 3'b111;
        inst_next.lb      = is_load && funct3 == 3'b000;
        inst_next.lh      = is_load && funct3 == 3'b001;
        inst_next.lw      = is_load && funct3 == 3'b010;
        inst_next.lbu     = is_load && funct3 == 3'b100;
        inst_next.lhu     = is_load && funct3 == 3'b101;
        inst_next.sb      = is_store && funct3 == 3'b000;
        inst_next.sh      = is_store && funct3 == 3'b001;
        inst_next.sw      = is_store && funct3 == 3'b010;
        inst_next.addi    = is_imm && funct3 == 3'b000;
        inst_next.slti    = is_imm && funct3 == 3'b010;
        inst_next.sltiu   = is_imm && funct3 == 3'b011;
        inst_next.xori    = is_imm && funct3 == 3'b100;
        inst_next.ori     = is_imm && funct3 == 3'b110;
        inst_next.andi    = is_imm && funct3 == 3'b111;
        inst_next.slli    = is_imm && funct3 == 3'b001 && f7_base;
        inst_next.srli    = is_imm && funct3 == 3'b101 && f7_base;
        inst_next.srai    = is_imm && funct3 == 3'b101 && f7_alt;
        inst_next.add     = is_reg && funct3 == 3'b000 && f7_base;
        inst_next.sub     = is_reg && funct3 == 3'b000 && f7_alt;
        inst_next.sll     = is_reg && funct3 == 3'b001 && f7_base;
        inst_next.slt     = is_reg && funct3 == 3'b010 && f7_base;
        inst_next.sltu    = is_reg && funct3 == 3'b011 && f7_base;
        inst_next.xor_op  = is_reg && funct3 == 3'b100 && f7_base;
        inst_next.srl     = is_reg && funct3 == 3'b101 && f7_base;
        inst_next.sra     = is_reg && funct3 == 3'b101 && f7_alt;
        inst_next.or_op   = is_reg && funct3 == 3'b110 && f7_base;
        inst_next.and_op  = is_reg && funct3 == 3'b111 && f7_base;
        inst_next.fence   = is_fence && funct3 == 3'b000;
        inst_next.fence_i = is_fence && funct3 == 3'b001;
        inst_next.ecall   = is_system && funct3 == 3'b000 && imm12 == funct12_ecall;
        inst_next.ebreak  = is_system && funct3 == 3'b000 && imm12 == funct12_ebreak;
        inst_next.mret    = is_system && funct3 == 3'b000 && imm12 == funct12_mret;
        inst_next.csrrw   = is_system && funct3 == 3'b001;
        inst_next.csrrs   = is_system && funct3 == 3'b010;
        inst_next.csrrc   = is_system && funct3 == 3'b011;
        inst_next.csrrwi  = is_system && funct3 == 3'b101;
        inst_next.csrrsi  = is_system && funct3 == 3'b110;
        inst_next.csrrci  = is_system && funct3 == 3'b111;
        inst_next.mul     = is_reg && funct3 == 3'b000 && f7_md;
        inst_next.mulh    = is_reg && funct3 == 3'b001 && f7_md;
        inst_next.mulhsu  = is_reg && funct3 == 3'b010 && f7_md;
        inst_next.mulhu   = is_reg && funct3 == 3'b011 && f7_md;
        inst_next.div     = is_reg && funct3 == 3'b100 && f7_md;
        inst_next.divu    = is_reg && funct3 == 3'b101 && f7_md;
        inst_next.rem     = is_reg && funct3 == 3'b110 && f7_md;
        inst_next.remu    = is_reg && funct3 == 3'b111 && f7_md;

        inst_next.access_mem = is_load || is_store;
        inst_next.update_reg = rd_num_gated != 5'd0;
        inst_next.update_csr = is_system && funct3 != 3'b000;
        // trap entry and return
        inst_next.update_pc  = j_form || opcode == op_jalr || is_branch ||
            (is_system && funct3 == 3'b000);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_rd_num  <= '0;
            de_rs1_num <= '0;
            de_rs2_num <= '0;
            de_csr_num <= '0;
            csr_zimm   <= '0;
            imm        <= '0;
            inst       <= '0;
            de_valid   <= 1'b0;
        end else if (de_ready) begin
            de_rd_num  <= rd_num_gated;
            de_rs1_num <= if_rs1_num;
            de_rs2_num <= if_rs2_num;
            de_csr_num <= csr_num_gated;
            csr_zimm   <= csr_i_form ? inst_code.i_view.rs1_or_zimm : 5'd0;
            imm        <= imm_next;
            inst       <= inst_next;
            de_valid   <= 1'b1;
        end else if (!ex_stall) begin
            // bubble
            de_rd_num  <= '0;
            de_rs1_num <= '0;
            de_rs2_num <= '0;
            de_csr_num <= '0;
            csr_zimm   <= '0;
            imm        <= '0;
            inst       <= '0;
            de_valid   <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(inst[$bits(inst_t)-1:inst_ctrl_bits]))
    else $error("more than one instruction flag set");

    assert property (@(posedge clk) disable iff (!rst_n)
        !de_ready && !ex_stall |=> !de_valid)
    else $error("de_valid survived a bubble cycle");

endmodule

//--- verilog/rip_front.sv
`timescale 1ns/1ps

module rip_front (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 de_ready,
    input  logic                 ex_stall,
    input  logic [31:0]          inst_code,
    input  logic [31:0]          pc,
    input  logic                 wb_en,
    input  logic [4:0]           wb_rd,
    input  logic [31:0]          wb_data,
    output rip_pkg::rip_ex_req_t ex_req
);
    import rip_pkg::*;

    // early read numbers go straight to the register file
    logic [4:0]  if_rs1_num;
    logic [4:0]  if_rs2_num;
    logic [4:0]  de_rd_num;
    logic [11:0] de_csr_num;
    logic [4:0]  csr_zimm;
    logic [31:0] imm;
    inst_t       inst;
    logic        de_valid;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    rip_decode rip_decode_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .de_ready   (de_ready),
        .ex_stall   (ex_stall),
        .inst_code  (inst_code),
        .if_rs1_num (if_rs1_num),
        .if_rs2_num (if_rs2_num),
        .de_rd_num  (de_rd_num),
        .de_rs1_num (),
        .de_rs2_num (),
        .de_csr_num (de_csr_num),
        .csr_zimm   (csr_zimm),
        .imm        (imm),
        .inst       (inst),
        .de_valid   (de_valid)
    );

    rip_regfile rip_regfile_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_stall (ex_stall),
        .rs1_num  (if_rs1_num),
        .rs2_num  (if_rs2_num),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rip_operand_sel rip_operand_sel_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .de_ready (de_ready),
        .ex_stall (ex_stall),
        .pc       (pc),
        .inst     (inst),
        .de_valid (de_valid),
        .rd       (de_rd_num),
        .csr_num  (de_csr_num),
        .csr_zimm (csr_zimm),
        .imm      (imm),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ex_req   (ex_req)
    );

endmodule

//--- verilog/rip_operand_sel.sv
`timescale 1ns/1ps

module rip_operand_sel (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 de_ready,
    input  logic                 ex_stall,
    input  logic [31:0]          pc,
    input  rip_pkg::inst_t       inst,
    input  logic                 de_valid,
    input  logic [4:0]           rd,
    input  logic [11:0]          csr_num,
    input  logic [4:0]           csr_zimm,
    input  logic [31:0]          imm,
    input  logic [31:0]          rs1_data,
    input  logic [31:0]          rs2_data,
    output rip_pkg::rip_ex_req_t ex_req
);
    import rip_pkg::*;

    logic [31:0] pc_q;
    logic        r_form;
    logic        branch;
    logic        csr_imm_form;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (de_ready) begin
            pc_q <= pc;
        end else if (!ex_stall) begin
            pc_q <= '0;
        end
    end

    assign r_form = inst.add || inst.sub || inst.sll || inst.slt || inst.sltu ||
        inst.xor_op || inst.srl || inst.sra || inst.or_op || inst.and_op ||
        inst.mul || inst.mulh || inst.mulhsu || inst.mulhu ||
        inst.div || inst.divu || inst.rem || inst.remu;
    assign branch = inst.beq || inst.bne || inst.blt || inst.bge || inst.bltu || inst.bgeu;
    assign csr_imm_form = inst.csrrwi || inst.csrrsi || inst.csrrci;

    always_comb begin
        ex_req            = '0;
        ex_req.valid      = de_valid;
        ex_req.inst       = inst;
        ex_req.rd         = rd;
        ex_req.csr_num    = csr_num;
        ex_req.csr_zimm   = csr_zimm;
        ex_req.pc         = pc_q;
        ex_req.store_data = rs2_data;

        // jalr target base stays rs1
        if (inst.auipc || inst.jal) begin
            ex_req.op_a = pc_q;
        end else if (inst.lui) begin
            ex_req.op_a = '0;
        end else if (csr_imm_form) begin
            ex_req.op_a = {27'b0, csr_zimm};
        end else begin
            ex_req.op_a = rs1_data;
        end

        if (r_form || branch) begin
            ex_req.op_b = rs2_data;
        end else if (inst.jal || inst.jalr) begin
            ex_req.op_b = 32'd4;
        end else begin
            ex_req.op_b = imm;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !ex_req.valid |-> ex_req.op_a == '0 && ex_req.op_b == '0)
    else $error("bubble carries nonzero operands");

endmodule

//--- verilog/rip_pkg.sv
package rip_pkg;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_fence  = 7'b0001111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [6:0] funct7_base   = 7'b0000000;
    localparam logic [6:0] funct7_alt    = 7'b0100000;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    // funct12 of the privileged system words
    localparam logic [11:0] funct12_ecall  = 12'h000;
    localparam logic [11:0] funct12_ebreak = 12'h001;
    localparam logic [11:0] funct12_mret   = 12'h302;

    // pipeline control bits sit in the low end of inst_t
    localparam int inst_ctrl_bits = 4;

    typedef struct packed {
        logic lui, auipc, jal, jalr;
        logic beq, bne, blt, bge, bltu, bgeu;
        logic lb, lh, lw, lbu, lhu;
        logic sb, sh, sw;
        logic addi, slti, sltiu, xori, ori, andi;
        logic slli, srli, srai;
        logic add, sub, sll, slt, sltu;
        logic xor_op, srl, sra, or_op, and_op;
        logic fence, fence_i;
        logic ecall, ebreak, mret;
        logic csrrw, csrrs, csrrc, csrrwi, csrrsi, csrrci;
        logic mul, mulh, mulhsu, mulhu;
        logic div, divu, rem, remu;
        logic access_mem;
        logic update_reg;
        logic update_csr;
        logic update_pc;
    } inst_t;

    // register-form view of the instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // immediate-form view, imm12 doubles as the csr number
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1_or_zimm;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } rip_inst_u;

    typedef struct packed {
        logic        valid;
        inst_t       inst;
        logic [4:0]  rd;
        logic [11:0] csr_num;
        logic [4:0]  csr_zimm;
        logic [31:0] pc;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] store_data;
    } rip_ex_req_t;

endpackage

//--- verilog/rip_regfile.sv
`timescale 1ns/1ps

module rip_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ex_stall,
    input  logic [4:0]  rs1_num,
    input  logic [4:0]  rs2_num,
    input  logic        wb_en,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    // write-through on a same-edge writeback
    function automatic logic [31:0] read_port(input logic [4:0] num);
        if (num == 5'd0) begin
            return '0;
        end
        if (wb_en && wb_rd == num) begin
            return wb_data;
        end
        return regs[num];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rs1_data <= '0;
            rs2_data <= '0;
        end else if (!ex_stall) begin
            rs1_data <= read_port(rs1_num);
            rs2_data <= read_port(rs2_num);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !$past(ex_stall) |-> ($past(rs1_num) != 5'd0 || rs1_data == '0)
        && ($past(rs2_num) != 5'd0 || rs2_data == '0))
    else $error("read of x0 returned nonzero data");

endmodule
